// ==== include/hello_defs.svh ====
`ifndef HELLO_DEFS_SVH
`define HELLO_DEFS_SVH

// Host bus widths
`define DATA_WIDTH      128
`define STRB_WIDTH      16
`define ADDR_WIDTH      32
`define ID_WIDTH        5

// Register access
`define WORD_WIDTH      32
`define CFG_ADDR_WIDTH  8

// --------------------------------------------------
// Register map
// --------------------------------------------------
`define HELLO_OFFS      8'h00

// Value returned for offsets with no register behind them
`define UNMAPPED_RDATA  32'hFFFF_FFFF

`endif

// ==== rtl/hello_pkg.sv ====
`default_nettype none

`include "hello_defs.svh"

package hello_pkg;

   // Bus fields
   typedef logic [`DATA_WIDTH-1:0]     data_bus_t;
   typedef logic [`STRB_WIDTH-1:0]     strb_t;
   typedef logic [`ADDR_WIDTH-1:0]     addr_t;
   typedef logic [`ID_WIDTH-1:0]       id_t;

   // Register side
   typedef logic [`WORD_WIDTH-1:0]     word_t;
   typedef logic [`CFG_ADDR_WIDTH-1:0] cfg_addr_t;

   // Slave FSM states
   typedef enum logic [1:0] {
      SLV_IDLE    = 2'd0,
      SLV_WR_ADDR = 2'd1,
      SLV_CYC     = 2'd2,
      SLV_RESP    = 2'd3
   } slv_state_t;

endpackage

`default_nettype wire

// ==== rtl/pcis_req_slice.sv ====
`default_nettype none

module pcis_req_slice
(
   input  logic                 clk_main_a0,
   input  logic                 rst_main_n,

   // Write address
   input  hello_pkg::id_t       awid,
   input  hello_pkg::addr_t     awaddr,
   input  logic                 awvalid,
   output logic                 awready,
   output hello_pkg::id_t       awid_q,
   output hello_pkg::addr_t     awaddr_q,
   output logic                 awvalid_q,
   input  logic                 awready_q,

   // Write data
   input  hello_pkg::data_bus_t wdata,
   input  hello_pkg::strb_t     wstrb,
   input  logic                 wvalid,
   output logic                 wready,
   output hello_pkg::data_bus_t wdata_q,
   output hello_pkg::strb_t     wstrb_q,
   output logic                 wvalid_q,
   input  logic                 wready_q,

   // Read address
   input  hello_pkg::id_t       arid,
   input  hello_pkg::addr_t     araddr,
   input  logic                 arvalid,
   output logic                 arready,
   output hello_pkg::id_t       arid_q,
   output hello_pkg::addr_t     araddr_q,
   output logic                 arvalid_q,
   input  logic                 arready_q
);

   // Channel order in the flag vectors: [2] read addr, [1] write data, [0] write addr
   logic [2:0] in_valid;
   logic [2:0] in_ready;
   logic [2:0] out_ready;
   logic [2:0] full;
   logic [2:0] load;

   assign in_valid  = {arvalid, wvalid, awvalid};
   assign out_ready = {arready_q, wready_q, awready_q};

   // Room when empty or when the entry drains this cycle
   assign in_ready  = ~full | out_ready;
   assign load      = in_valid & in_ready;

   assign {arready, wready, awready}       = in_ready;
   assign {arvalid_q, wvalid_q, awvalid_q} = full;

   //--------------------------------------------------
   // Full flags
   //--------------------------------------------------
   always_ff @(posedge clk_main_a0)
      if (!rst_main_n)
         full <= '0;
      else
         full <= load | (full & ~out_ready);

   // Held payload, loaded on each accepted beat
   always_ff @(posedge clk_main_a0)
   begin
      if (load[0])
      begin
         awid_q   <= awid;
         awaddr_q <= awaddr;
      end
      if (load[1])
      begin
         wdata_q  <= wdata;
         wstrb_q  <= wstrb;
      end
      if (load[2])
      begin
         arid_q   <= arid;
         araddr_q <= araddr;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/pcis_slave_fsm.sv ====
`default_nettype none

`include "hello_defs.svh"

module pcis_slave_fsm
(
   input  logic                 clk_main_a0,
   input  logic                 rst_main_n,

   // Requests from the slice
   input  hello_pkg::id_t       awid_q,
   input  hello_pkg::addr_t     awaddr_q,
   input  logic                 awvalid_q,
   input  hello_pkg::data_bus_t wdata_q,
   input  logic                 wvalid_q,
   input  hello_pkg::id_t       arid_q,
   input  hello_pkg::addr_t     araddr_q,
   input  logic                 arvalid_q,
   output logic                 awready_q,
   output logic                 wready_q,
   output logic                 arready_q,

   // Write response
   output hello_pkg::id_t       bid,
   output logic [1:0]           bresp,
   output logic                 bvalid,
   input  logic                 bready,

   // Read response
   output hello_pkg::id_t       rid,
   output hello_pkg::data_bus_t rdata,
   output logic [1:0]           rresp,
   output logic                 rlast,
   output logic                 rvalid,
   input  logic                 rready,

   // Configuration block
   output hello_pkg::cfg_addr_t cfg_addr,
   output hello_pkg::word_t     cfg_wdata,
   output logic                 cfg_wr,
   output logic                 cfg_rd,
   input  logic                 cfg_ack,
   input  hello_pkg::word_t     cfg_rdata
);

   import hello_pkg::*;

   localparam logic [1:0] RESP_OKAY = 2'b00;

   slv_state_t slv_state;
   slv_state_t slv_state_nxt;

   logic       slv_cyc_wr;
   logic       slv_did_req;
   logic       slv_issue;
   logic       slv_req_valid;
   logic       slv_rsp_ready;
   addr_t      req_wr_addr;
   addr_t      req_rd_addr;
   id_t        req_wr_id;
   id_t        req_rd_id;
   addr_t      mx_addr;
   word_t      wr_lane;
   word_t      slv_rdata;

   // Write data is needed only for a write cycle
   assign slv_req_valid = slv_cyc_wr ? wvalid_q : 1'b1;
   assign slv_rsp_ready = slv_cyc_wr ? bready : rready;
   assign mx_addr       = slv_cyc_wr ? req_wr_addr : req_rd_addr;
   assign wr_lane       = wdata_q[req_wr_addr[3:2]*`WORD_WIDTH +: `WORD_WIDTH];

   // Capture both channels in idle; write wins
   always_ff @(posedge clk_main_a0)
      if (slv_state == SLV_IDLE)
      begin
         req_wr_addr <= awaddr_q;
         req_wr_id   <= awid_q;
         req_rd_addr <= araddr_q;
         req_rd_id   <= arid_q;
      end

   //--------------------------------------------------
   // State machine
   //--------------------------------------------------
   always_comb
   begin
      slv_state_nxt = slv_state;
      case (slv_state)
         SLV_IDLE:
            if (awvalid_q)
               slv_state_nxt = SLV_WR_ADDR;
            else if (arvalid_q)
               slv_state_nxt = SLV_CYC;
         SLV_WR_ADDR:
            slv_state_nxt = SLV_CYC;
         SLV_CYC:
            if (cfg_ack)
               slv_state_nxt = SLV_RESP;
         SLV_RESP:
            if (slv_rsp_ready)
               slv_state_nxt = SLV_IDLE;
         default:
            slv_state_nxt = SLV_IDLE;
      endcase
   end

   // One strobe per access
   assign slv_issue = (slv_state == SLV_CYC) && slv_req_valid && !slv_did_req;

   always_ff @(posedge clk_main_a0)
      if (!rst_main_n)
      begin
         slv_state   <= SLV_IDLE;
         slv_cyc_wr  <= 1'b0;
         slv_did_req <= 1'b0;
         cfg_wr      <= 1'b0;
         cfg_rd      <= 1'b0;
         awready_q   <= 1'b0;
         wready_q    <= 1'b0;
         arready_q   <= 1'b0;
      end
      else
      begin
         slv_state   <= slv_state_nxt;
         if (slv_state == SLV_IDLE)
            slv_cyc_wr <= awvalid_q;
         slv_did_req <= (slv_state != SLV_IDLE) && (slv_did_req || slv_issue);
         cfg_wr      <= slv_issue && slv_cyc_wr;
         cfg_rd      <= slv_issue && !slv_cyc_wr;
         // Ready pulses back to the slice
         awready_q   <= (slv_state == SLV_IDLE) && (slv_state_nxt == SLV_WR_ADDR);
         wready_q    <= (slv_state == SLV_CYC) && (slv_state_nxt != SLV_CYC) && slv_cyc_wr;
         arready_q   <= (slv_state == SLV_CYC) && (slv_state_nxt != SLV_CYC) && !slv_cyc_wr;
      end

   // Address and lane word, aligned with the strobe
   always_ff @(posedge clk_main_a0)
   begin
      cfg_addr  <= mx_addr[`CFG_ADDR_WIDTH-1:0];
      cfg_wdata <= wr_lane;
      if (cfg_ack)
         slv_rdata <= cfg_rdata;
   end

   //--------------------------------------------------
   // Responses
   //--------------------------------------------------
   assign bid    = req_wr_id;
   assign bresp  = RESP_OKAY;
   assign bvalid = (slv_state == SLV_RESP) && slv_cyc_wr;

   // Read word goes back in its own lane
   always_comb
   begin
      rdata = '0;
      rdata[req_rd_addr[3:2]*`WORD_WIDTH +: `WORD_WIDTH] = slv_rdata;
   end

   assign rid    = req_rd_id;
   assign rresp  = RESP_OKAY;
   assign rlast  = 1'b1;
   assign rvalid = (slv_state == SLV_RESP) && !slv_cyc_wr;

endmodule

`default_nettype wire

// ==== rtl/cfg_reg_block.sv ====
`default_nettype none

`include "hello_defs.svh"

module cfg_reg_block
(
   input  logic                 clk_main_a0,
   input  logic                 rst_main_n,
   input  hello_pkg::cfg_addr_t cfg_addr,
   input  hello_pkg::word_t     cfg_wdata,
   input  logic                 cfg_wr,
   input  logic                 cfg_rd,
   output logic                 cfg_ack,
   output hello_pkg::word_t     cfg_rdata
);

   import hello_pkg::*;

   logic      wr_stretch;
   logic      rd_stretch;
   cfg_addr_t addr_q;
   word_t     wdata_q;
   word_t     hello_world_q;

   //--------------------------------------------------
   // Command stretch and capture
   //--------------------------------------------------
   // Strobes are single pulses; hold them until the ack
   always_ff @(posedge clk_main_a0)
      if (!rst_main_n)
      begin
         wr_stretch <= 1'b0;
         rd_stretch <= 1'b0;
      end
      else
      begin
         wr_stretch <= cfg_wr || (wr_stretch && !cfg_ack);
         rd_stretch <= cfg_rd || (rd_stretch && !cfg_ack);
      end

   always_ff @(posedge clk_main_a0)
      if (cfg_wr || cfg_rd)
      begin
         addr_q  <= cfg_addr;
         wdata_q <= cfg_wdata;
      end

   // Hello World register
   always_ff @(posedge clk_main_a0)
      if (!rst_main_n)
         hello_world_q <= '0;
      else if (wr_stretch && (addr_q == `HELLO_OFFS))
         hello_world_q <= wdata_q;

   // Readback is byte-swapped at the Hello World offset
   always_ff @(posedge clk_main_a0)
      case (addr_q)
         `HELLO_OFFS:
            cfg_rdata <= {hello_world_q[7:0],   hello_world_q[15:8],
                          hello_world_q[23:16], hello_world_q[31:24]};
         default:
            cfg_rdata <= `UNMAPPED_RDATA;
      endcase

   // Single-cycle ack
   always_ff @(posedge clk_main_a0)
      if (!rst_main_n)
         cfg_ack <= 1'b0;
      else
         cfg_ack <= (wr_stretch || rd_stretch) && !cfg_ack;

endmodule

`default_nettype wire

// ==== rtl/hello_world_top.sv ====
`default_nettype none

module hello_world_top
(
   input  logic                 clk_main_a0,
   input  logic                 rst_main_n,

   // Request channels
   input  hello_pkg::id_t       awid,
   input  hello_pkg::addr_t     awaddr,
   input  logic                 awvalid,
   output logic                 awready,
   input  hello_pkg::data_bus_t wdata,
   input  hello_pkg::strb_t     wstrb,
   input  logic                 wvalid,
   output logic                 wready,
   input  hello_pkg::id_t       arid,
   input  hello_pkg::addr_t     araddr,
   input  logic                 arvalid,
   output logic                 arready,

   // Response channels
   output hello_pkg::id_t       bid,
   output logic [1:0]           bresp,
   output logic                 bvalid,
   input  logic                 bready,
   output hello_pkg::id_t       rid,
   output hello_pkg::data_bus_t rdata,
   output logic [1:0]           rresp,
   output logic                 rlast,
   output logic                 rvalid,
   input  logic                 rready
);

   // --------------------------------------------------
   // Slice to slave
   // --------------------------------------------------
   hello_pkg::id_t       awid_q;
   hello_pkg::addr_t     awaddr_q;
   logic                 awvalid_q;
   logic                 awready_q;
   hello_pkg::data_bus_t wdata_q;
   logic                 wvalid_q;
   logic                 wready_q;
   hello_pkg::id_t       arid_q;
   hello_pkg::addr_t     araddr_q;
   logic                 arvalid_q;
   logic                 arready_q;

   // Slave to configuration block
   hello_pkg::cfg_addr_t cfg_addr;
   hello_pkg::word_t     cfg_wdata;
   logic                 cfg_wr;
   logic                 cfg_rd;
   logic                 cfg_ack;
   hello_pkg::word_t     cfg_rdata;

   // Byte strobes stop at the slice; every write is a full word
   pcis_req_slice u_slice (.wstrb_q (), .*);

   pcis_slave_fsm u_slave (.*);

   cfg_reg_block  u_cfg   (.*);

endmodule

`default_nettype wire

// ==== bench/clk_gen.sv ====
`default_nettype none

module clk_gen
#(
   parameter int HALF_PERIOD = 2
)
(
   output logic clk
);

   initial
      clk = 1'b0;

   // Free-running clock, period 2*HALF_PERIOD
   always
      #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

// ==== bench/tb_hello_world.sv ====
`default_nettype none

`include "hello_defs.svh"

module tb_hello_world;

   import hello_pkg::*;

   parameter int SEED = 89377;

   localparam int    WAIT_LIMIT = 64;
   localparam int    MAX_STALL  = 6;
   localparam string STIM_FILE  = "bench/hello_stim.txt";

   logic       clk_main_a0;
   logic       rst_main_n;
   id_t        awid;
   addr_t      awaddr;
   logic       awvalid;
   logic       awready;
   data_bus_t  wdata;
   strb_t      wstrb;
   logic       wvalid;
   logic       wready;
   id_t        arid;
   addr_t      araddr;
   logic       arvalid;
   logic       arready;
   id_t        bid;
   logic [1:0] bresp;
   logic       bvalid;
   logic       bready;
   id_t        rid;
   data_bus_t  rdata;
   logic [1:0] rresp;
   logic       rlast;
   logic       rvalid;
   logic       rready;

   int errors;
   int tests_run;
   int tests_failed;
   bit aborted;

   clk_gen u_clk (.clk (clk_main_a0));

   hello_world_top u_dut (.*);

   task automatic report_mismatch(input string msg);
      $display("[FAIL] %0t: %s", $time, msg);
      errors++;
   endtask

   // One word in the lane picked by addr[3:2], every other lane set to fill
   function automatic data_bus_t place_word(input word_t word, input word_t fill,
                                            input addr_t addr);
      data_bus_t bus;
      bus = {(`DATA_WIDTH/`WORD_WIDTH){fill}};
      bus[addr[3:2]*`WORD_WIDTH +: `WORD_WIDTH] = word;
      return bus;
   endfunction

   //--------------------------------------------------
   // Request side
   //--------------------------------------------------
   // Each channel drops its valid after its own handshake
   task automatic send_requests(input bit do_wr, input bit do_rd, input id_t id,
                                input addr_t addr, input word_t word);
      int waited;
      bit aw_take;
      bit w_take;
      bit ar_take;
      awid    = id;
      awaddr  = addr;
      wdata   = place_word(word, ~word, addr);
      wstrb   = '1;
      arid    = id;
      araddr  = addr;
      awvalid = do_wr;
      wvalid  = do_wr;
      arvalid = do_rd;
      waited  = 0;
      while ((awvalid || wvalid || arvalid) && waited < WAIT_LIMIT)
      begin
         aw_take = awvalid && awready;
         w_take  = wvalid && wready;
         ar_take = arvalid && arready;
         @(negedge clk_main_a0);
         if (aw_take)
            awvalid = 1'b0;
         if (w_take)
            wvalid = 1'b0;
         if (ar_take)
            arvalid = 1'b0;
         waited++;
      end
      if (awvalid || wvalid || arvalid)
      begin
         $display("Timeout: request not accepted (awvalid %0b, wvalid %0b, arvalid %0b)",
                  awvalid, wvalid, arvalid);
         aborted = 1'b1;
      end
   endtask

   //--------------------------------------------------
   // Response side
   //--------------------------------------------------
   task automatic take_write_resp(input id_t exp_id);
      int  waited;
      int  stall;
      id_t held_id;
      waited = 0;
      while (!bvalid && waited < WAIT_LIMIT)
      begin
         assert (!rvalid) else report_mismatch("rvalid seen before the write response");
         @(negedge clk_main_a0);
         waited++;
      end
      if (!bvalid)
      begin
         $display("Timeout: the write response channel never raised bvalid");
         aborted = 1'b1;
         return;
      end
      assert (bid == exp_id) else report_mismatch($sformatf("bid %0h, expected %0h",
                                                              bid, exp_id));
      assert (bresp == 2'b00) else report_mismatch($sformatf("bresp %0b, expected OKAY", bresp));
      held_id = bid;
      // Hold bready low for a random stretch
      stall = $urandom % MAX_STALL;
      repeat (stall)
      begin
         @(negedge clk_main_a0);
         assert (bvalid && bid == held_id)
            else report_mismatch("write response changed while bready was low");
      end
      bready = 1'b1;
      @(negedge clk_main_a0);
      bready = 1'b0;
      assert (!bvalid) else report_mismatch("second write response after acceptance");
   endtask

   task automatic take_read_resp(input id_t exp_id, input addr_t addr, input word_t exp_word);
      int        waited;
      int        stall;
      id_t       held_id;
      data_bus_t held_data;
      data_bus_t exp_data;
      exp_data = place_word(exp_word, '0, addr);
      waited   = 0;
      while (!rvalid && waited < WAIT_LIMIT)
      begin
         @(negedge clk_main_a0);
         waited++;
      end
      if (!rvalid)
      begin
         $display("Timeout: the read response channel never raised rvalid");
         aborted = 1'b1;
         return;
      end
      assert (rid == exp_id) else report_mismatch($sformatf("rid %0h, expected %0h",
                                                              rid, exp_id));
      assert (rdata == exp_data)
         else report_mismatch($sformatf("rdata %h, expected %h", rdata, exp_data));
      assert (rresp == 2'b00) else report_mismatch($sformatf("rresp %0b, expected OKAY", rresp));
      assert (rlast) else report_mismatch("rlast low on a read response");
      held_id   = rid;
      held_data = rdata;
      stall = $urandom % MAX_STALL;
      repeat (stall)
      begin
         @(negedge clk_main_a0);
         assert (rvalid && rid == held_id && rdata == held_data)
            else report_mismatch("read response changed while rready was low");
      end
      rready = 1'b1;
      @(negedge clk_main_a0);
      rready = 1'b0;
      assert (!rvalid) else report_mismatch("second read response after acceptance");
      assert (!bvalid) else report_mismatch("write response appeared after a read");
   endtask

   //--------------------------------------------------
   // Main sequence
   //--------------------------------------------------
   initial
   begin
      int          fd;
      int          n;
      int          tnum;
      int          err_before;
      string       line;
      string       op;
      logic [31:0] id_v;
      logic [31:0] addr_v;
      logic [31:0] wr_v;
      logic [31:0] rd_v;
      rst_main_n   = 1'b0;
      awid         = '0;
      awaddr       = '0;
      awvalid      = 1'b0;
      wdata        = '0;
      wstrb        = '0;
      wvalid       = 1'b0;
      arid         = '0;
      araddr       = '0;
      arvalid      = 1'b0;
      bready       = 1'b0;
      rready       = 1'b0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      aborted      = 1'b0;
      void'($urandom(SEED));
      repeat (2) @(negedge clk_main_a0);
      rst_main_n = 1'b1;

      // Quiet bus after reset
      repeat (10)
      begin
         @(negedge clk_main_a0);
         assert (!bvalid && !rvalid) else report_mismatch("response valid on an idle bus");
      end

      fd = $fopen(STIM_FILE, "r");
      if (fd == 0)
      begin
         $display("Could not open the stimulus file %s", STIM_FILE);
         aborted = 1'b1;
      end
      while (!aborted && !$feof(fd))
      begin
         line = "";
         if ($fgets(line, fd) == 0)
            continue;
         if (line.len() == 0 || line.getc(0) == "#")
            continue;
         n = $sscanf(line, "%d %s %h %h %h %h", tnum, op, id_v, addr_v, wr_v, rd_v);
         if (n <= 0)
            continue;
         if (n != 6 || !(op == "W" || op == "R" || op == "B"))
         begin
            $display("Stimulus line not understood: %s", line);
            errors++;
            continue;
         end
         err_before = errors;
         send_requests(op != "R", op != "W", id_v[`ID_WIDTH-1:0], addr_v, wr_v);
         if (!aborted && op != "R")
            take_write_resp(id_v[`ID_WIDTH-1:0]);
         if (!aborted && op != "W")
            take_read_resp(id_v[`ID_WIDTH-1:0], addr_v, rd_v);
         tests_run++;
         if (errors != err_before || aborted)
            tests_failed++;
         $display("test %0d %s id %02h addr %08h: %s", tnum, op, id_v, addr_v,
                  (errors == err_before && !aborted) ? "ok" : "FAILED");
      end
      if (fd != 0)
         $fclose(fd);

      $display("Tests run: %0d, failed: %0d, check errors: %0d", tests_run, tests_failed, errors);
      if (errors == 0 && !aborted)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

// ==== bench/hello_stim.txt ====
# test op id addr write_word expect_read_word (all but test in hex)
# op W = write, R = read, B = write and read in the same cycle
1 R 03 00000000 00000000 00000000
2 W 0A 00000000 12345678 00000000
3 R 0B 00000000 00000000 78563412
4 R 0C 00000008 00000000 FFFFFFFF
5 R 0D 0000000C 00000000 FFFFFFFF
6 R 0E 00000004 00000000 FFFFFFFF
7 W 0F 00000008 DEADBEEF 00000000
8 W 10 0000000C CAFEF00D 00000000
9 W 11 00000004 55AA55AA 00000000
10 R 12 00000000 00000000 78563412
11 B 13 00000000 A1B2C3D4 D4C3B2A1
12 W 14 00001100 0BADF00D 00000000
13 R 15 00000000 00000000 0DF0AD0B
14 B 16 00000048 00000001 FFFFFFFF
15 R 17 00000000 00000000 0DF0AD0B
16 B 18 00000100 89ABCDEF EFCDAB89
17 R 1F 0000000C 00000000 FFFFFFFF
18 W 00 00000000 00FF00FF 00000000
19 R 01 00000000 00000000 FF00FF00
20 B 1E 0000FF00 01020304 04030201
21 R 1D 00000000 00000000 04030201
22 R 1C 00000044 00000000 FFFFFFFF
23 R 1B 00000000 00000000 04030201

// ==== vlog.f ====
+incdir+include
rtl/hello_pkg.sv
rtl/pcis_req_slice.sv
rtl/pcis_slave_fsm.sv
rtl/cfg_reg_block.sv
rtl/hello_world_top.sv
bench/clk_gen.sv
bench/tb_hello_world.sv

// ==== Makefile ====
TOP       ?= tb_hello_world
SEED      ?= 89377
LOG       ?= sim.log
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir

SRCS := $(shell grep -v '^+' vlog.f) $(wildcard include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): vlog.f $(SRCS)
	$(VERILATOR) --binary --timing --assert -Wno-fatal -GSEED=$(SEED) \
		--top-module $(TOP) -Mdir $(OBJ_DIR) -f vlog.f

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Done: errors found" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
